// ==== Makefile ====
# Verilator simulation of the bridge data buffer

VERILATOR ?= verilator
TOP       ?= u109Bridge_tb
FILELIST  ?= u109Bridge.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== beatFifo.sv ====
// Beat FIFO, show-ahead synchronous buffer of bus words with count, empty and full
`timescale 1ns/1ns

module beatFifo #(
    parameter int fifoDepth = 8
) (
    input  logic                   BCLK,
    input  logic                   nRESET,
    input  logic                   push,
    input  bridgePkg::busWord_t    pushData,
    input  logic                   pop,
    output bridgePkg::busWord_t    head,
    output bridgePkg::fifoStatus_t status
);

    import bridgePkg::*;

    localparam int ptrWidth = $clog2(fifoDepth);
    localparam int cntWidth = ptrWidth + 1;

    // Depth sanity at elaboration
    if ((fifoDepth < 2) || ((fifoDepth & (fifoDepth - 1)) != 0)) begin : gDepthCheck
        $error("beatFifo depth must be a power of two of at least 2");
    end
    if (cntWidth > fifoCountWidth) begin : gCountCheck
        $error("beatFifo depth exceeds the status count field");
    end

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    busWord_t            mem [fifoDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                empty;
    logic                full;
    logic                doPush;
    logic                doPop;

    assign empty = (count == '0);
    assign full  = (count == cntWidth'(fifoDepth));

    // Push dropped when full, pop dropped when empty
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    // Word store
    always_ff @(posedge BCLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on a push and pop in the same cycle
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            count <= '0;
        end else begin
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Show-ahead, oldest word sits at the read pointer
    assign head = mem[rdPtr];

    always_comb begin
        status.empty = empty;
        status.full  = full;
        status.count = fifoCountWidth'(count);
    end

endmodule

// ==== bridgePkg.sv ====
// Bridge package with the bus word, transfer and acknowledge types shared by the data buffer
package bridgePkg;

    //////////////////////////////////////////////////////////////////////
    // Bus word
    //////////////////////////////////////////////////////////////////////

    // Both the CPU data bus and PCI AD are 32 bits wide
    localparam int busWidth = 32;

    typedef logic [busWidth-1:0] busWord_t;

    // Count field width, holds 0..8 for the default FIFO depth
    localparam int fifoCountWidth = 4;

    //////////////////////////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////////////////////////

    // Encoded as {TT1, TT0}
    // Only TT0 high with TT1 low is a line burst
    typedef enum logic [1:0] {
        XferSingle = 2'b00,
        XferBurst  = 2'b01,
        XferOther  = 2'b10
    } xferType_e;

    // Acknowledge FSM states
    typedef enum logic [1:0] {
        TaIdle = 2'd0,
        TaBeat = 2'd1,
        TaHold = 2'd2
    } taState_e;

    //////////////////////////////////////////////////////////////////////
    // Bus bundles
    //////////////////////////////////////////////////////////////////////

    // CPU side, active low except the type
    typedef struct packed {
        logic      nTs;
        xferType_e tt;
        logic      nBg;
        logic      nBen;
    } cpuBus_t;

    // PCI side controls
    typedef struct packed {
        logic nIrdy;
        logic nTrdy;
        logic pciCycle;
        logic pciDir;   // high means CPU to PCI
    } pciBus_t;

    // Modelled tristate line, level only counts while en is high
    typedef struct packed {
        logic en;
        logic level;
    } triLine_t;

    // FIFO occupancy
    typedef struct packed {
        logic                      empty;
        logic                      full;
        logic [fifoCountWidth-1:0] count;
    } fifoStatus_t;

endpackage

// ==== busSteering.sv ====
// Bus steering, picks FIFO push and pop sources by direction and sets the data-bus drive enables
`timescale 1ns/1ns

module busSteering (
    input  bridgePkg::cpuBus_t     cpuIn,
    input  bridgePkg::pciBus_t     pciIn,
    input  bridgePkg::busWord_t    cpuData,
    input  bridgePkg::busWord_t    adIn,
    input  logic                   taBeat,
    input  bridgePkg::fifoStatus_t status,
    input  bridgePkg::busWord_t    head,
    output logic                   beatReady,
    output logic                   push,
    output bridgePkg::busWord_t    pushData,
    output logic                   pop,
    output bridgePkg::busWord_t    dOut,
    output logic                   dDrive,
    output bridgePkg::busWord_t    adOut,
    output logic                   adDrive
);

    logic pciBeat;
    logic cpuToPci;

    //////////////////////////////////////////////////////////////////////
    // Handshake decode
    //////////////////////////////////////////////////////////////////////

    // PCI word moves when both ready strobes are low
    assign pciBeat  = !pciIn.nIrdy && !pciIn.nTrdy;
    assign cpuToPci = pciIn.pciDir;

    // CPU side waits for room on writes and for data on reads
    assign beatReady = cpuToPci ? !status.full : !status.empty;

    //////////////////////////////////////////////////////////////////////
    // FIFO source and sink
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cpuToPci) begin
            // CPU write, acknowledged beats fill and PCI drains
            push     = taBeat;
            pushData = cpuData;
            pop      = pciBeat && !status.empty;
        end else begin
            // CPU read, PCI fills and acknowledged beats drain
            // Overflowing PCI beat is dropped
            push     = pciBeat && !status.full;
            pushData = adIn;
            pop      = taBeat;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data bus drive
    //////////////////////////////////////////////////////////////////////

    // Both buses show the FIFO head
    assign dOut  = head;
    assign adOut = head;

    // D driven on reads with the buffer selected
    assign dDrive = !cpuIn.nBen && !cpuToPci;

    // AD driven on writes during a PCI cycle
    assign adDrive = pciIn.pciCycle && cpuToPci;

endmodule

// ==== transferAck.sv ====
// Transfer acknowledge FSM, counts single and burst beats and drives the three-state nTa line
`timescale 1ns/1ns

module transferAck (
    input  logic                BCLK,
    input  logic                nRESET,
    input  bridgePkg::cpuBus_t  cpuIn,
    input  logic                beatReady,
    output logic                taBeat,
    output bridgePkg::triLine_t nTa
);

    import bridgePkg::*;

    taState_e  state;
    taState_e  stateNext;
    logic      tsReg;
    xferType_e xferReg;
    logic [1:0] beatsLeft;
    logic      startOk;

    //////////////////////////////////////////////////////////////////////
    // Start decode
    //////////////////////////////////////////////////////////////////////

    // Registered start, only honoured with the bus granted and buffer on
    assign startOk = tsReg && !cpuIn.nBg && !cpuIn.nBen;

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            tsReg   <= 1'b0;
            xferReg <= XferSingle;
        end else begin
            tsReg <= !cpuIn.nTs;
            // Type is valid alongside the start strobe
            if (!cpuIn.nTs) begin
                xferReg <= cpuIn.tt;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Beat sequencing
    //////////////////////////////////////////////////////////////////////

    // A beat completes when data is ready on the FIFO side
    assign taBeat = (state == TaBeat) && beatReady && !cpuIn.nBen;

    always_comb begin
        stateNext = state;
        case (state)
            TaIdle:  if (startOk) stateNext = TaBeat;
            TaBeat:  if (taBeat && (beatsLeft == 2'd0)) stateNext = TaHold;
            TaHold:  stateNext = TaIdle;
            default: stateNext = TaIdle;
        endcase
    end

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state     <= TaIdle;
            beatsLeft <= 2'd0;
        end else begin
            state <= stateNext;
            // Remaining beats after the current one, three more for a line burst
            if ((state == TaIdle) && startOk) begin
                beatsLeft <= (xferReg == XferBurst) ? 2'd3 : 2'd0;
            end else if (taBeat && (beatsLeft != 2'd0)) begin
                beatsLeft <= beatsLeft - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Acknowledge line
    //////////////////////////////////////////////////////////////////////

    // Hold cycle keeps nTa high so a floating line cannot end the next cycle
    always_comb begin
        case (state)
            TaBeat: begin
                nTa.en    = 1'b1;
                nTa.level = !taBeat;
            end
            TaHold: begin
                nTa.en    = 1'b1;
                nTa.level = 1'b1;
            end
            default: begin
                // Idle, held high only while the buffer is selected
                nTa.en    = !cpuIn.nBen;
                nTa.level = 1'b1;
            end
        endcase
    end

endmodule

// ==== u109Bridge.f ====
bridgePkg.sv
beatFifo.sv
transferAck.sv
busSteering.sv
u109Bridge.sv
u109Bridge_asserts.sv
u109Bridge_tb.sv

// ==== u109Bridge.sv ====
// U109 bridge data buffer top, joins the acknowledge FSM, bus steering and beat FIFO
`timescale 1ns/1ns

module u109Bridge #(
    parameter int fifoDepth = 8
) (
    input  logic                BCLK,
    input  logic                nRESET,
    input  bridgePkg::cpuBus_t  cpuIn,
    input  bridgePkg::pciBus_t  pciIn,
    input  bridgePkg::busWord_t cpuData,
    input  bridgePkg::busWord_t adIn,
    output bridgePkg::busWord_t dOut,
    output logic                dDrive,
    output bridgePkg::busWord_t adOut,
    output logic                adDrive,
    output bridgePkg::triLine_t nTa
);

    import bridgePkg::*;

    // Internal nets between the three blocks
    logic        beatReady;
    logic        taBeat;
    logic        push;
    logic        pop;
    busWord_t    pushData;
    busWord_t    head;
    fifoStatus_t status;

    // CPU acknowledge
    transferAck i_transferAck (
        .BCLK      (BCLK),
        .nRESET    (nRESET),
        .cpuIn     (cpuIn),
        .beatReady (beatReady),
        .taBeat    (taBeat),
        .nTa       (nTa)
    );

    // Direction steering
    busSteering i_busSteering (
        .cpuIn     (cpuIn),
        .pciIn     (pciIn),
        .cpuData   (cpuData),
        .adIn      (adIn),
        .taBeat    (taBeat),
        .status    (status),
        .head      (head),
        .beatReady (beatReady),
        .push      (push),
        .pushData  (pushData),
        .pop       (pop),
        .dOut      (dOut),
        .dDrive    (dDrive),
        .adOut     (adOut),
        .adDrive   (adDrive)
    );

    // Word buffer
    beatFifo #(
        .fifoDepth (fifoDepth)
    ) i_beatFifo (
        .BCLK     (BCLK),
        .nRESET   (nRESET),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .head     (head),
        .status   (status)
    );

endmodule

// ==== u109Bridge_asserts.sv ====
// Bridge protocol assertions on acknowledge release, FIFO guards and the hold cycle
`timescale 1ns/1ns

module u109Bridge_asserts (
    input logic                   BCLK,
    input logic                   nRESET,
    input bridgePkg::cpuBus_t     cpuIn,
    input bridgePkg::triLine_t    nTa,
    input logic                   push,
    input logic                   pop,
    input bridgePkg::fifoStatus_t status,
    input bridgePkg::taState_e    ackState
);

    import bridgePkg::*;

    // Acknowledge only goes low with the buffer selected
    ackNeedsBen: assert property (@(posedge BCLK) disable iff (!nRESET)
        (nTa.en && !nTa.level) |-> !cpuIn.nBen)
        else $error("nTa driven low while nBen is high");

    // FIFO guards
    noPushFull: assert property (@(posedge BCLK) disable iff (!nRESET)
        push |-> !status.full)
        else $error("FIFO push while full");

    noPopEmpty: assert property (@(posedge BCLK) disable iff (!nRESET)
        pop |-> !status.empty)
        else $error("FIFO pop while empty");

    // Hold cycle drives the line high and lasts one cycle
    holdHigh: assert property (@(posedge BCLK) disable iff (!nRESET)
        (ackState == TaHold) |-> (nTa.en && nTa.level))
        else $error("nTa not driven high in the hold cycle");

    holdOnce: assert property (@(posedge BCLK) disable iff (!nRESET)
        (ackState == TaHold) |=> (ackState != TaHold))
        else $error("hold state lasted more than one cycle");

endmodule

bind u109Bridge u109Bridge_asserts i_u109BridgeAsserts (
    .BCLK     (BCLK),
    .nRESET   (nRESET),
    .cpuIn    (cpuIn),
    .nTa      (nTa),
    .push     (push),
    .pop      (pop),
    .status   (status),
    .ackState (i_transferAck.state)
);

// ==== u109Bridge_tb.sv ====
// Bridge data buffer testbench checking CPU and PCI cycles against a reference queue
`timescale 1ns/1ns

module u109Bridge_tb;

    import bridgePkg::*;

    localparam int clkPeriod  = 40;
    localparam int driveDelay = 2;
    localparam int waitLimit  = 40;

    logic        BCLK;
    logic        nRESET;
    cpuBus_t     cpuIn;
    pciBus_t     pciIn;
    busWord_t    cpuData;
    busWord_t    adIn;
    busWord_t    dOut;
    logic        dDrive;
    busWord_t    adOut;
    logic        adDrive;
    triLine_t    nTa;
    int unsigned lcgState = 89864;
    // Expected FIFO contents with the oldest word first
    busWord_t    refQ [$];

    u109Bridge #(.fifoDepth(8)) i_u109Bridge (.*);

    initial begin
        BCLK = 1'b0;
        forever #(clkPeriod / 2) BCLK = ~BCLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic busWord_t nextWord();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input busWord_t got, input busWord_t expected);
        assert (got === expected) else
            abortRun($sformatf("mismatch at %0t ns: %s expected %h got %h",
                               $time, name, expected, got));
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        assert (got === expected) else
            abortRun($sformatf("mismatch at %0t ns: %s expected %b got %b",
                               $time, name, expected, got));
    endtask

    // Step to the drive point just after the rising edge
    task automatic stepToDrive();
        @(posedge BCLK);
        #driveDelay;
    endtask

    // Ends on the falling edge of the acknowledged cycle
    task automatic waitAckLow();
        int n;
        for (n = 0; n < waitLimit; n++) begin
            @(negedge BCLK);
            if (nTa.en && !nTa.level) break;
            stepToDrive();
        end
        if (n == waitLimit) abortRun("timeout waiting for nTa to be driven low");
    endtask

    task automatic waitEmpty();
        int n;
        for (n = 0; n < waitLimit; n++) begin
            @(negedge BCLK);
            if (i_u109Bridge.status.empty) break;
        end
        if (n == waitLimit) abortRun("timeout waiting for the FIFO to drain");
        stepToDrive();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus cycles
    //////////////////////////////////////////////////////////////////////

    // One-cycle start strobe with the bus granted
    task automatic startTransfer(input xferType_e t);
        cpuIn.nBen = 1'b0;
        cpuIn.nBg  = 1'b0;
        cpuIn.nTs  = 1'b0;
        cpuIn.tt   = t;
        stepToDrive();
        cpuIn.nTs = 1'b1;
    endtask

    // Hold cycle high and then a released line once the buffer is deselected
    task automatic finishTransfer();
        @(negedge BCLK);
        checkBit("nTa.en", nTa.en, 1'b1);
        checkBit("nTa.level", nTa.level, 1'b1);
        stepToDrive();
        cpuIn.nBen = 1'b1;
        @(negedge BCLK);
        checkBit("nTa.en", nTa.en, 1'b0);
        stepToDrive();
    endtask

    task automatic cpuWrite(input int beats, input xferType_e t);
        int b;
        pciIn.pciDir = 1'b1;
        cpuData      = nextWord();
        startTransfer(t);
        for (b = 0; b < beats; b++) begin
            waitAckLow();
            refQ.push_back(cpuData);
            stepToDrive();
            cpuData = nextWord();
        end
        finishTransfer();
    endtask

    task automatic readBeats(input int beats);
        int b;
        for (b = 0; b < beats; b++) begin
            waitAckLow();
            checkBit("dDrive", dDrive, 1'b1);
            checkValue("status.count", busWord_t'(i_u109Bridge.status.count), refQ.size());
            checkValue("dOut", dOut, refQ.pop_front());
            stepToDrive();
        end
    endtask

    // PCI target drains the FIFO onto AD
    task automatic pciDrain(input int words);
        int k;
        pciIn = '{nIrdy: 1'b0, nTrdy: 1'b0, pciCycle: 1'b1, pciDir: 1'b1};
        for (k = 0; k < words; k++) begin
            @(negedge BCLK);
            checkBit("adDrive", adDrive, 1'b1);
            checkValue("status.count", busWord_t'(i_u109Bridge.status.count), refQ.size());
            checkValue("adOut", adOut, refQ.pop_front());
            stepToDrive();
        end
        pciIn = '{nIrdy: 1'b1, nTrdy: 1'b1, pciCycle: 1'b0, pciDir: 1'b1};
        waitEmpty();
    endtask

    // PCI master fills the FIFO from AD
    task automatic pciFill(input int words);
        int k;
        pciIn = '{nIrdy: 1'b0, nTrdy: 1'b0, pciCycle: 1'b1, pciDir: 1'b0};
        for (k = 0; k < words; k++) begin
            adIn = nextWord();
            refQ.push_back(adIn);
            stepToDrive();
        end
        pciIn = '{nIrdy: 1'b1, nTrdy: 1'b1, pciCycle: 1'b0, pciDir: 1'b0};
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        nRESET  = 1'b0;
        cpuIn   = '{nTs: 1'b1, tt: XferSingle, nBg: 1'b1, nBen: 1'b1};
        pciIn   = '{nIrdy: 1'b1, nTrdy: 1'b1, pciCycle: 1'b0, pciDir: 1'b1};
        cpuData = '0;
        adIn    = '0;
        repeat (5) @(posedge BCLK);
        #driveDelay;
        nRESET = 1'b1;

        // Idle outputs and a PCI pop on the empty FIFO
        @(negedge BCLK);
        checkBit("nTa.en", nTa.en, 1'b0);
        checkBit("dDrive", dDrive, 1'b0);
        checkBit("adDrive", adDrive, 1'b0);
        stepToDrive();
        pciIn = '{nIrdy: 1'b0, nTrdy: 1'b0, pciCycle: 1'b1, pciDir: 1'b1};
        @(negedge BCLK);
        checkBit("adDrive", adDrive, 1'b1);
        checkBit("dDrive", dDrive, 1'b0);
        stepToDrive();
        pciIn = '{nIrdy: 1'b1, nTrdy: 1'b1, pciCycle: 1'b0, pciDir: 1'b1};
        @(negedge BCLK);
        checkBit("status.empty", i_u109Bridge.status.empty, 1'b1);
        stepToDrive();

        // Writes toward PCI
        cpuWrite(1, XferSingle);
        pciDrain(1);
        cpuWrite(4, XferBurst);
        pciDrain(4);

        // Burst read from PCI data
        pciFill(4);
        startTransfer(XferBurst);
        readBeats(4);
        finishTransfer();

        // Fill to full and offer one more PCI word that must be dropped
        pciFill(8);
        pciIn = '{nIrdy: 1'b0, nTrdy: 1'b0, pciCycle: 1'b1, pciDir: 1'b0};
        adIn  = nextWord();
        stepToDrive();
        pciIn = '{nIrdy: 1'b1, nTrdy: 1'b1, pciCycle: 1'b0, pciDir: 1'b0};
        @(negedge BCLK);
        checkBit("status.full", i_u109Bridge.status.full, 1'b1);
        checkValue("status.count", busWord_t'(i_u109Bridge.status.count), refQ.size());
        stepToDrive();
        startTransfer(XferBurst);
        readBeats(4);
        finishTransfer();
        startTransfer(XferBurst);
        readBeats(4);
        finishTransfer();

        // Read stalls on the empty FIFO until PCI supplies a word
        pciIn.pciDir = 1'b0;
        startTransfer(XferSingle);
        repeat (6) begin
            @(negedge BCLK);
            checkBit("nTa.en", nTa.en, 1'b1);
            checkBit("nTa.level", nTa.level, 1'b1);
            stepToDrive();
        end

        // Deselected buffer holds off the acknowledge with data ready
        cpuIn.nBen = 1'b1;
        pciFill(1);
        @(negedge BCLK);
        checkBit("nTa.level", nTa.level, 1'b1);
        stepToDrive();
        cpuIn.nBen = 1'b0;
        readBeats(1);
        finishTransfer();

        $display("TEST PASS");
        $finish;
    end

endmodule
